//--- Bender.yml
package:
  name: mem_wb

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/apb_pkg.sv
      - rtl/mem_align.sv
      - rtl/apb_data_master.sv
      - rtl/rd_wmux.sv
      - rtl/mem_wb_stage.sv
  - target: test
    files:
      - verif/apb_mem_model.sv
      - verif/mem_wb_props.sv
      - verif/tb_mem_wb.sv

//--- project.f
rtl/lsu_pkg.sv
rtl/apb_pkg.sv
rtl/mem_align.sv
rtl/apb_data_master.sv
rtl/rd_wmux.sv
rtl/mem_wb_stage.sv
verif/apb_mem_model.sv
verif/mem_wb_props.sv
verif/tb_mem_wb.sv

//--- rtl/apb_data_master.sv
`timescale 1ns/10ps

module apb_data_master import apb_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	// request from the stage
	input  logic                  start,
	input  logic                  write,
	input  logic [apb_addr_w-1:0] addr,
	input  logic [apb_data_w-1:0] wdata,
	input  logic [apb_strb_w-1:0] strb,
	// slave response
	input  logic                  pready,
	input  logic [apb_data_w-1:0] prdata,
	input  logic                  pslverr,
	// bus request
	output logic [apb_addr_w-1:0] paddr,
	output logic                  psel,
	output logic                  penable,
	output logic                  pwrite,
	output logic [apb_data_w-1:0] pwdata,
	output logic [apb_strb_w-1:0] pstrb,
	// completion back to the stage
	output logic                  done,
	output logic [apb_data_w-1:0] rdata,
	output logic                  err
);

	apb_state_t state_q;
	logic       take_req;

	// a request is only taken while the bus is idle
	assign take_req = start && (state_q == apb_idle);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= apb_idle;
		end else begin
			case (state_q)
				apb_idle: begin
					if (start) begin
						state_q <= apb_setup;
					end
				end
				apb_setup: begin
					state_q <= apb_access;
				end
				apb_access: begin
					// wait states keep us here
					if (pready) begin
						state_q <= apb_idle;
					end
				end
				default: begin
					state_q <= apb_idle;
				end
			endcase
		end
	end

	// address, control and data held for the whole transfer
	always_ff @(posedge clk) begin
		if (take_req) begin
			paddr  <= addr;
			pwrite <= write;
			pwdata <= wdata;
			pstrb  <= strb;
		end
	end

	assign psel    = (state_q != apb_idle);
	assign penable = (state_q == apb_access);

	// completion is the access cycle that sees pready
	assign done  = penable && pready;
	assign rdata = prdata;
	assign err   = done && pslverr;

endmodule

//--- rtl/apb_pkg.sv
package apb_pkg;

	// byte address on the data bus
	localparam int apb_addr_w = 32;

	// one full dword per beat
	localparam int apb_data_w = 64;

	// one strobe bit per byte lane
	localparam int apb_strb_w = apb_data_w / 8;

	// transfer phases of the master
	// idle means psel low
	// setup is the single cycle with psel high and penable low
	// access holds psel and penable high until pready
	typedef enum logic [1:0] {
		apb_idle   = 2'b00,
		apb_setup  = 2'b01,
		apb_access = 2'b10
	} apb_state_t;

endpackage

//--- rtl/lsu_pkg.sv
package lsu_pkg;

	// integer register width
	localparam int xlen = 64;

	// register file index width
	localparam int reg_idx_w = 5;

	// access size codes as they come from the decoder
	localparam logic [1:0] size_byte  = 2'b00;
	localparam logic [1:0] size_half  = 2'b01;
	localparam logic [1:0] size_word  = 2'b10;
	localparam logic [1:0] size_dword = 2'b11;

	// eight byte lanes, lane 0 at the lowest address
	typedef struct packed {
		logic [7:0][7:0] lane;
	} byte_lanes_t;

	// four halfword lanes
	typedef struct packed {
		logic [3:0][15:0] lane;
	} half_lanes_t;

	// two word lanes
	typedef struct packed {
		logic [1:0][31:0] lane;
	} word_lanes_t;

	// one bus dword seen whole or split into lanes of any access size
	typedef union packed {
		logic [xlen-1:0] dword;
		byte_lanes_t b;
		half_lanes_t h;
		word_lanes_t w;
	} dword_view_t;

endpackage

//--- rtl/mem_align.sv
`timescale 1ns/10ps

module mem_align import lsu_pkg::*, apb_pkg::*; (
	input  logic [xlen-1:0]       addr,
	input  logic [1:0]            size,
	input  logic [xlen-1:0]       store_data,
	output logic [apb_addr_w-1:0] bus_addr,
	output logic [apb_strb_w-1:0] strb,
	output logic [apb_data_w-1:0] lane_data,
	output logic                  misaligned
);

	logic [2:0]            offset;
	logic [apb_strb_w-1:0] size_mask;
	dword_view_t           lane_view;

	assign offset = addr[2:0];

	// bus works on whole dwords
	assign bus_addr = {addr[apb_addr_w-1:3], 3'b000};

	// strobe pattern of the access before it is moved to its offset
	always_comb begin
		case (size)
			size_byte: size_mask = 8'h01;
			size_half: size_mask = 8'h03;
			size_word: size_mask = 8'h0f;
			default:   size_mask = 8'hff;
		endcase
	end

	assign strb = size_mask << offset;

	// place the store value into the lane picked by the offset
	// unused lanes stay zero and are masked by strb anyway
	always_comb begin
		lane_view = '0;
		case (size)
			size_byte: lane_view.b.lane[offset] = store_data[7:0];
			size_half: lane_view.h.lane[offset[2:1]] = store_data[15:0];
			size_word: lane_view.w.lane[offset[2]] = store_data[31:0];
			default:   lane_view.dword = store_data;
		endcase
	end

	assign lane_data = lane_view.dword;

	// natural alignment required, no splitting
	always_comb begin
		case (size)
			size_byte: misaligned = 1'b0;
			size_half: misaligned = offset[0];
			size_word: misaligned = |offset[1:0];
			default:   misaligned = |offset;
		endcase
	end

endmodule

//--- rtl/mem_wb_stage.sv
`timescale 1ns/10ps

module mem_wb_stage import lsu_pkg::*, apb_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	// issue side
	input  logic                  issue_valid,
	output logic                  issue_ready,
	input  logic [xlen-1:0]       alu_result,
	input  logic [xlen-1:0]       store_data,
	input  logic [reg_idx_w-1:0]  rd_idx,
	input  logic                  mem_read,
	input  logic                  mem_write,
	input  logic [1:0]            mem_size,
	input  logic                  mem_unsigned,
	input  logic                  csr_rena,
	input  logic [xlen-1:0]       csr_data,
	// writeback side
	output logic                  wb_we,
	output logic [reg_idx_w-1:0]  wb_idx,
	output logic [xlen-1:0]       wb_data,
	output logic                  fault,
	// apb master port
	output logic [apb_addr_w-1:0] paddr,
	output logic                  psel,
	output logic                  penable,
	output logic                  pwrite,
	output logic [apb_data_w-1:0] pwdata,
	output logic [apb_strb_w-1:0] pstrb,
	input  logic                  pready,
	input  logic [apb_data_w-1:0] prdata,
	input  logic                  pslverr
);

	logic                  busy;
	logic                  accept;
	logic                  mem_op;
	logic                  start;
	logic                  misaligned;
	logic [apb_addr_w-1:0] bus_addr;
	logic [apb_strb_w-1:0] strb;
	logic [apb_data_w-1:0] lane_data;
	logic                  done;
	logic [apb_data_w-1:0] rdata;
	logic                  err;
	logic [xlen-1:0]       rd_wdata;
	// operation held while its transfer is open
	logic                  load_q;
	logic [reg_idx_w-1:0]  rd_idx_q;
	logic [1:0]            size_q;
	logic                  unsigned_q;
	logic [2:0]            offset_q;

	// stalled from accept of a memory op until its completion edge
	assign issue_ready = !busy;
	assign accept      = issue_valid && issue_ready;
	assign mem_op      = mem_read || mem_write;
	assign start       = accept && mem_op && !misaligned;

	mem_align i_align (
		.addr       (alu_result),
		.size       (mem_size),
		.store_data (store_data),
		.bus_addr   (bus_addr),
		.strb       (strb),
		.lane_data  (lane_data),
		.misaligned (misaligned)
	);

	apb_data_master i_master (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.write   (mem_write),
		.addr    (bus_addr),
		.wdata   (lane_data),
		.strb    (strb),
		.pready  (pready),
		.prdata  (prdata),
		.pslverr (pslverr),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.done    (done),
		.rdata   (rdata),
		.err     (err)
	);

	// while busy the mux sees the captured load, otherwise the issuing op
	rd_wmux i_wmux (
		.alu_result  (alu_result),
		.mem_data    (rdata),
		.csr_data    (csr_data),
		.csr_rena    (csr_rena && !busy),
		.mem_to_reg  (busy),
		.mem_ext_un  (busy ? unsigned_q : mem_unsigned),
		.mem_size    (busy ? size_q : mem_size),
		.byte_offset (busy ? offset_q : alu_result[2:0]),
		.rd_wdata    (rd_wdata)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy  <= 1'b0;
			wb_we <= 1'b0;
			fault <= 1'b0;
		end else begin
			// both are single cycle pulses
			wb_we <= 1'b0;
			fault <= 1'b0;
			if (done) begin
				busy <= 1'b0;
				// slave error replaces the write, stores never write back
				fault <= err;
				wb_we <= !err && load_q;
			end
			if (accept) begin
				if (!mem_op) begin
					wb_we <= 1'b1;
				end else if (misaligned) begin
					fault <= 1'b1;
				end else begin
					busy <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && mem_op) begin
			load_q     <= !mem_write;
			rd_idx_q   <= rd_idx;
			size_q     <= mem_size;
			unsigned_q <= mem_unsigned;
			offset_q   <= alu_result[2:0];
		end
		// writeback value follows whichever op finishes this cycle
		if (accept || done) begin
			wb_idx  <= accept ? rd_idx : rd_idx_q;
			wb_data <= rd_wdata;
		end
	end

endmodule

//--- rtl/rd_wmux.sv
`timescale 1ns/10ps

module rd_wmux import lsu_pkg::*; (
	input  logic [xlen-1:0] alu_result,
	input  logic [xlen-1:0] mem_data,
	input  logic [xlen-1:0] csr_data,
	input  logic            csr_rena,
	input  logic            mem_to_reg,
	input  logic            mem_ext_un,
	input  logic [1:0]      mem_size,
	input  logic [2:0]      byte_offset,
	output logic [xlen-1:0] rd_wdata
);

	dword_view_t     view;
	logic [7:0]      byte_lane;
	logic [15:0]     half_lane;
	logic [31:0]     word_lane;
	logic [xlen-1:0] load_val;

	assign view = mem_data;

	// lane selected by the low address bits
	assign byte_lane = view.b.lane[byte_offset];
	assign half_lane = view.h.lane[byte_offset[2:1]];
	assign word_lane = view.w.lane[byte_offset[2]];

	// extend to register width, mem_ext_un set means zero fill
	always_comb begin
		case (mem_size)
			size_byte: begin
				load_val = mem_ext_un ? {{(xlen-8){1'b0}}, byte_lane} :
					{{(xlen-8){byte_lane[7]}}, byte_lane};
			end
			size_half: begin
				load_val = mem_ext_un ? {{(xlen-16){1'b0}}, half_lane} :
					{{(xlen-16){half_lane[15]}}, half_lane};
			end
			size_word: begin
				load_val = mem_ext_un ? {{(xlen-32){1'b0}}, word_lane} :
					{{(xlen-32){word_lane[31]}}, word_lane};
			end
			default: begin
				load_val = view.dword;
			end
		endcase
	end

	// csr read wins over a load, a load wins over the alu
	always_comb begin
		if (csr_rena) begin
			rd_wdata = csr_data;
		end else if (mem_to_reg) begin
			rd_wdata = load_val;
		end else begin
			rd_wdata = alu_result;
		end
	end

endmodule

//--- verif/apb_mem_model.sv
`timescale 1ns/10ps

module apb_mem_model import apb_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_data_w-1:0] pwdata,
	input  logic [apb_strb_w-1:0] pstrb,
	output logic                  pready,
	output logic [apb_data_w-1:0] prdata,
	output logic                  pslverr
);

	// 256 dwords cover 0x000 to 0x7ff
	logic [apb_data_w-1:0] mem [256];
	logic [31:0]           rng;
	logic [1:0]            wait_q;
	logic                  in_err;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// every dword gets its own pattern
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = {4{i[7:0], ~i[7:0]}} ^ 64'h0f1e_2d3c_4b5a_6978;
		end
	end

	// everything from 0x800 up answers with a slave error
	assign in_err  = (paddr >= 32'h800);
	assign pready  = penable && (wait_q == 2'd0);
	assign pslverr = pready && in_err;
	assign prdata  = mem[paddr[10:3]];

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rng    <= 32'h88da;
			wait_q <= 2'd0;
		end else if (psel && !penable) begin
			// setup cycle draws 0 to 3 wait states
			rng    <= xorshift(rng);
			wait_q <= rng[1:0];
		end else if (penable && (wait_q != 2'd0)) begin
			wait_q <= wait_q - 2'd1;
		end
	end

	// only strobed lanes change, error region is read only
	always @(posedge clk) begin
		if (pready && pwrite && !in_err) begin
			for (int b = 0; b < apb_strb_w; b++) begin
				if (pstrb[b]) begin
					mem[paddr[10:3]][8*b +: 8] <= pwdata[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- verif/mem_wb_props.sv
`timescale 1ns/10ps

module mem_wb_props import apb_pkg::*; (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  issue_valid,
	input logic                  issue_ready,
	input logic                  mem_read,
	input logic                  mem_write,
	input logic                  misaligned,
	input logic                  wb_we,
	input logic                  fault,
	input logic [apb_addr_w-1:0] paddr,
	input logic                  psel,
	input logic                  penable,
	input logic                  pwrite,
	input logic [apb_data_w-1:0] pwdata,
	input logic [apb_strb_w-1:0] pstrb,
	input logic                  pready,
	input logic                  pslverr,
	input apb_state_t            state
);

	int   fail_cnt = 0;
	logic plain_acc;
	logic mem_acc;

	assign plain_acc = issue_valid && issue_ready && !mem_read && !mem_write;
	assign mem_acc   = issue_valid && issue_ready && (mem_read || mem_write);

	// outputs quiet on the first edge out of reset
	reset_idle: assert property (@(posedge clk) $rose(arst_n) |->
		!wb_we && !fault && !psel && !penable && issue_ready)
	else begin
		fail_cnt++;
		$error("outputs not idle after reset");
	end

	// plain op writes back one cycle after acceptance
	plain_latency: assert property (@(posedge clk) disable iff (!arst_n)
		plain_acc |=> wb_we && !fault)
	else begin
		fail_cnt++;
		$error("plain operation missed its one cycle writeback");
	end

	misaligned_fault: assert property (@(posedge clk) disable iff (!arst_n)
		mem_acc && misaligned |=> fault && !wb_we && !psel)
	else begin
		fail_cnt++;
		$error("misaligned access did not fault cleanly");
	end

	// access phase only ever comes straight from setup
	enable_after_setup: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(penable) |-> $past(psel && !penable))
	else begin
		fail_cnt++;
		$error("penable rose without a setup cycle");
	end

	// stage only hands a memory op over while the master sits in idle
	start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		mem_acc && !misaligned |-> state == apb_idle)
	else begin
		fail_cnt++;
		$error("memory operation accepted while the apb master was busy");
	end

	// request fields frozen until the completing edge
	hold_request: assert property (@(posedge clk) disable iff (!arst_n)
		psel && !(penable && pready) |=> psel && $stable(paddr) && $stable(pwrite)
		&& $stable(pwdata) && $stable(pstrb))
	else begin
		fail_cnt++;
		$error("apb request changed before pready");
	end

	stall_on_bus: assert property (@(posedge clk) disable iff (!arst_n)
		psel |-> !issue_ready)
	else begin
		fail_cnt++;
		$error("issue side ready while a transfer is open");
	end

	slave_error_fault: assert property (@(posedge clk) disable iff (!arst_n)
		penable && pready && pslverr |=> fault && !wb_we)
	else begin
		fail_cnt++;
		$error("slave error did not turn into a fault");
	end

	one_outcome: assert property (@(posedge clk) disable iff (!arst_n)
		!(wb_we && fault))
	else begin
		fail_cnt++;
		$error("writeback and fault in the same cycle");
	end

endmodule

// every stage instance gets its checker
bind mem_wb_stage mem_wb_props i_props (
	.state (i_master.state_q),
	.*
);

//--- verif/tb_mem_wb.sv
`timescale 1ns/10ps

module tb_mem_wb import lsu_pkg::*, apb_pkg::*; ();

	localparam int n_ops      = 600;
	localparam int wait_limit = 64;

	logic                  clk;
	logic                  arst_n;
	logic                  issue_valid;
	logic                  issue_ready;
	logic [xlen-1:0]       alu_result;
	logic [xlen-1:0]       store_data;
	logic [reg_idx_w-1:0]  rd_idx;
	logic                  mem_read;
	logic                  mem_write;
	logic [1:0]            mem_size;
	logic                  mem_unsigned;
	logic                  csr_rena;
	logic [xlen-1:0]       csr_data;
	logic                  wb_we;
	logic [reg_idx_w-1:0]  wb_idx;
	logic [xlen-1:0]       wb_data;
	logic                  fault;
	logic [apb_addr_w-1:0] paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_strb_w-1:0] pstrb;
	logic                  pready;
	logic [apb_data_w-1:0] prdata;
	logic                  pslverr;

	// one entry per expected outcome: fault flag, rd index, write data
	logic [xlen+reg_idx_w:0] exp_q[$];
	logic [xlen-1:0]         shadow [256];
	logic [31:0]             rng = 32'h88da;
	int                      err_cnt;
	int                      check_cnt;
	int                      timeout_cnt;

	mem_wb_stage i_dut (.*);

	apb_mem_model i_mem (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// load result assembled byte by byte from the shadow dword
	function automatic logic [xlen-1:0] load_value(input logic [xlen-1:0] word,
		input logic [2:0] off, input logic [1:0] size, input logic zext);
		logic [xlen-1:0] val;
		int              nbytes;
		nbytes = 1 << size;
		val = '0;
		for (int k = 0; k < nbytes; k++) begin
			val[8*k +: 8] = word[8*(off+k) +: 8];
		end
		if (!zext && val[8*nbytes-1]) begin
			for (int k = nbytes; k < 8; k++) begin
				val[8*k +: 8] = 8'hff;
			end
		end
		return val;
	endfunction

	// drive one random op, wait for acceptance, then record what must follow
	task automatic issue_random;
		logic [31:0]     r;
		logic [1:0]      kind;
		logic [1:0]      size;
		logic [11:0]     addr;
		logic [xlen-1:0] value;
		logic [xlen-1:0] sdata;
		logic            unaligned;
		int              cnt;
		rng = xorshift(rng);
		r = rng;
		// 0 plain, 1 store, 2 and 3 load
		kind = r[1:0];
		size = r[3:2];
		// one in eight hits the error region, 32 dwords otherwise
		addr = {&r[6:4], 3'b000, r[14:7]};
		// mostly aligned
		if (r[20:18] != 3'b000) begin
			addr = addr & ~((12'd1 << size) - 12'd1);
		end
		unaligned = (addr & ((12'd1 << size) - 12'd1)) != 12'd0;
		rng = xorshift(rng);
		value = {rng, r};
		rng = xorshift(rng);
		sdata = {r ^ rng, rng};
		issue_valid  <= 1'b1;
		mem_read     <= kind[1];
		mem_write    <= (kind == 2'd1);
		mem_size     <= size;
		mem_unsigned <= r[21];
		csr_rena     <= (kind == 2'd0) && r[22];
		csr_data     <= ~sdata;
		rd_idx       <= r[27:23];
		alu_result   <= (kind == 2'd0) ? value : {{(xlen-12){1'b0}}, addr};
		store_data   <= sdata;
		cnt = 0;
		@(posedge clk);
		while (!issue_ready && cnt < wait_limit) begin
			@(posedge clk);
			cnt++;
		end
		if (!issue_ready) begin
			$display("timeout at %0t: operation not accepted within %0d cycles", $time, cnt);
			timeout_cnt++;
		end else if (kind == 2'd0) begin
			exp_q.push_back({1'b0, r[27:23], r[22] ? ~sdata : value});
		end else if (unaligned || addr[11]) begin
			exp_q.push_back({1'b1, {reg_idx_w{1'b0}}, {xlen{1'b0}}});
		end else if (kind == 2'd1) begin
			// stores touch only their own bytes
			for (int k = 0; k < (1 << size); k++) begin
				shadow[addr[10:3]][8*(addr[2:0]+k) +: 8] = sdata[8*k +: 8];
			end
		end else begin
			exp_q.push_back({1'b0, r[27:23],
				load_value(shadow[addr[10:3]], addr[2:0], size, r[21])});
		end
	endtask

	// each writeback or fault pulse consumes the oldest expectation
	always @(posedge clk) begin
		logic [xlen+reg_idx_w:0] expected;
		if (arst_n && (wb_we || fault)) begin
			check_cnt++;
			if (exp_q.size() == 0) begin
				$display("writeback or fault at %0t with no operation outstanding", $time);
				err_cnt++;
			end else begin
				expected = exp_q.pop_front();
				assert (fault == expected[xlen+reg_idx_w]) else begin
					$display("error: %0t fault expected %b actual %b", $time,
						expected[xlen+reg_idx_w], fault);
					err_cnt++;
				end
				if (!expected[xlen+reg_idx_w]) begin
					assert (wb_idx == expected[xlen +: reg_idx_w]) else begin
						$display("error: %0t wb_idx expected %0d actual %0d", $time,
							expected[xlen +: reg_idx_w], wb_idx);
						err_cnt++;
					end
					assert (wb_data == expected[xlen-1:0]) else begin
						$display("error: %0t wb_data expected %h actual %h", $time,
							expected[xlen-1:0], wb_data);
						err_cnt++;
					end
				end
			end
		end
	end

	task automatic finish_run;
		int assert_cnt;
		assert_cnt = i_dut.i_props.fail_cnt;
		$display("checks %0d, mismatches %0d, assertion failures %0d, timeouts %0d, missing %0d",
			check_cnt, err_cnt, assert_cnt, timeout_cnt, exp_q.size());
		if (err_cnt == 0 && assert_cnt == 0 && timeout_cnt == 0 && exp_q.size() == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	initial begin
		int cnt;
		arst_n       = 1'b0;
		issue_valid  = 1'b0;
		alu_result   = '0;
		store_data   = '0;
		rd_idx       = '0;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		mem_size     = size_byte;
		mem_unsigned = 1'b0;
		csr_rena     = 1'b0;
		csr_data     = '0;
		err_cnt      = 0;
		check_cnt    = 0;
		timeout_cnt  = 0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		// shadow starts from the slave's fill pattern
		for (int i = 0; i < 256; i++) begin
			shadow[i] = i_mem.mem[i];
		end
		for (int n = 0; n < n_ops; n++) begin
			issue_random();
			if (timeout_cnt != 0) begin
				break;
			end
		end
		issue_valid <= 1'b0;
		// drain the last results and any trailing store
		cnt = 0;
		while ((exp_q.size() != 0 || !issue_ready) && cnt < wait_limit) begin
			@(posedge clk);
			cnt++;
		end
		if (exp_q.size() != 0 || !issue_ready) begin
			$display("timeout at %0t: results still outstanding after the last op", $time);
			timeout_cnt++;
		end
		@(posedge clk);
		finish_run();
	end

endmodule
